/* logic/axil_master.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_master (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            start_write,
    input  axil_pkg::addr_t start_addr,
    input  axil_pkg::data_t start_wdata,
    input  logic            awready,
    input  logic            wready,
    input  logic            bvalid,
    input  axil_pkg::resp_t bresp,
    input  logic            arready,
    input  logic            rvalid,
    input  axil_pkg::data_t rdata,
    input  axil_pkg::resp_t rresp,
    output logic            done,
    output axil_pkg::data_t done_rdata,
    output logic            done_err,
    output logic            awvalid,
    output axil_pkg::addr_t awaddr,
    output logic            wvalid,
    output axil_pkg::data_t wdata,
    output logic            bready,
    output logic            arvalid,
    output axil_pkg::addr_t araddr,
    output logic            rready
);
    axil_pkg::aw_state_t aw_state, aw_n_state;
    axil_pkg::w_state_t  w_state, w_n_state;
    axil_pkg::r_state_t  r_state, r_n_state;

    axil_pkg::addr_t addr_q;
    axil_pkg::data_t wdata_q;
    axil_pkg::data_t rdata_q;
    logic            err_q;
    logic            w_success;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_state <= axil_pkg::AW_IDLE;
            w_state  <= axil_pkg::W_IDLE;
            r_state  <= axil_pkg::R_IDLE;
        end else begin
            aw_state <= aw_n_state;
            w_state  <= w_n_state;
            r_state  <= r_n_state;
        end
    end

    // address write, error responses also end in done
    always_comb begin
        case (aw_state)
            axil_pkg::AW_IDLE:
                aw_n_state = (start && start_write) ? axil_pkg::AW_SEND : axil_pkg::AW_IDLE;
            axil_pkg::AW_SEND:
                aw_n_state = awready ? axil_pkg::AW_RESP_WAIT : axil_pkg::AW_SEND;
            axil_pkg::AW_RESP_WAIT:
                aw_n_state = bvalid ? axil_pkg::AW_DONE : axil_pkg::AW_RESP_WAIT;
            default:
                aw_n_state = w_success ? axil_pkg::AW_IDLE : axil_pkg::AW_DONE;
        endcase
    end

    // write data
    always_comb begin
        case (w_state)
            axil_pkg::W_IDLE:
                w_n_state = (start && start_write) ? axil_pkg::W_SEND : axil_pkg::W_IDLE;
            axil_pkg::W_SEND:
                w_n_state = wready ? axil_pkg::W_RESP_WAIT : axil_pkg::W_SEND;
            axil_pkg::W_RESP_WAIT:
                w_n_state = bvalid ? axil_pkg::W_DONE : axil_pkg::W_RESP_WAIT;
            default:
                w_n_state = w_success ? axil_pkg::W_IDLE : axil_pkg::W_DONE;
        endcase
    end

    // read
    always_comb begin
        case (r_state)
            axil_pkg::R_IDLE:
                r_n_state = (start && !start_write) ? axil_pkg::R_ADDR_SEND : axil_pkg::R_IDLE;
            axil_pkg::R_ADDR_SEND:
                r_n_state = arready ? axil_pkg::R_DATA_WAIT : axil_pkg::R_ADDR_SEND;
            axil_pkg::R_DATA_WAIT:
                r_n_state = rvalid ? axil_pkg::R_DONE : axil_pkg::R_DATA_WAIT;
            default:
                r_n_state = axil_pkg::R_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= start_addr;
            wdata_q <= start_wdata;
            rdata_q <= '0;
            err_q   <= 1'b0;
        end else if (bvalid && bready) begin
            err_q <= bresp[1];
        end else if (rvalid && rready) begin
            rdata_q <= rdata;
            err_q   <= rresp[1];
        end
    end

    assign w_success = (aw_state == axil_pkg::AW_DONE) && (w_state == axil_pkg::W_DONE);

    assign awvalid = (aw_state == axil_pkg::AW_SEND);
    assign wvalid  = (w_state == axil_pkg::W_SEND);
    // ready only alongside the valid
    assign bready  = (w_state == axil_pkg::W_RESP_WAIT) && bvalid;
    assign arvalid = (r_state == axil_pkg::R_ADDR_SEND);
    assign rready  = (r_state == axil_pkg::R_DATA_WAIT) && rvalid;
    assign awaddr  = addr_q;
    assign araddr  = addr_q;
    assign wdata   = wdata_q;

    assign done       = w_success || (r_state == axil_pkg::R_DONE);
    assign done_rdata = rdata_q;
    assign done_err   = err_q;

endmodule

`default_nettype wire

/* logic/axil_pkg.sv */
`default_nettype none

package axil_pkg;

    // byte address, word index in bits 5:2
    typedef logic [7:0]  addr_t;
    typedef logic [31:0] data_t;
    typedef logic [1:0]  resp_t;
    typedef logic        client_t;

    localparam int NUM_REGS    = 16;
    localparam int REQ_CREDITS = 2;
    localparam int REQ_PTR_W   = $clog2(REQ_CREDITS);

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        AW_IDLE,
        AW_SEND,
        AW_RESP_WAIT,
        AW_DONE
    } aw_state_t;

    typedef enum logic [1:0] {
        W_IDLE,
        W_SEND,
        W_RESP_WAIT,
        W_DONE
    } w_state_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR_SEND,
        R_DATA_WAIT,
        R_DONE
    } r_state_t;

endpackage

`default_nettype wire

/* logic/axil_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_regfile (
    input  logic            clk,
    input  logic            rst,
    input  logic            awvalid,
    input  axil_pkg::addr_t awaddr,
    input  logic            wvalid,
    input  axil_pkg::data_t wdata,
    input  logic            bready,
    input  logic            arvalid,
    input  axil_pkg::addr_t araddr,
    input  logic            rready,
    output logic            awready,
    output logic            wready,
    output logic            bvalid,
    output axil_pkg::resp_t bresp,
    output logic            arready,
    output logic            rvalid,
    output axil_pkg::data_t rdata,
    output axil_pkg::resp_t rresp
);
    axil_pkg::data_t regs [axil_pkg::NUM_REGS];

    axil_pkg::addr_t awaddr_q;
    axil_pkg::data_t wdata_q;
    logic            aw_held;
    logic            w_held;
    logic            aw_now;
    logic            w_now;
    logic            ar_now;
    logic            do_write;
    axil_pkg::addr_t wr_addr;
    axil_pkg::data_t wr_data;

    assign aw_now   = awvalid && awready;
    assign w_now    = wvalid && wready;
    assign ar_now   = arvalid && arready;
    // use the live channel if it arrives in the same cycle as the other
    assign wr_addr  = aw_held ? awaddr_q : awaddr;
    assign wr_data  = w_held ? wdata_q : wdata;
    assign do_write = (aw_held || aw_now) && (w_held || w_now) && !bvalid;

    always_ff @(posedge clk) begin
        if (aw_now) awaddr_q <= awaddr;
        if (w_now) wdata_q <= wdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= axil_pkg::RESP_OKAY;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= axil_pkg::RESP_OKAY;
            for (int i = 0; i < axil_pkg::NUM_REGS; i++) regs[i] <= '0;
        end else begin
            awready <= awvalid && !awready && !aw_held && !bvalid;
            wready  <= wvalid && !wready && !w_held && !bvalid;
            arready <= arvalid && !arready && !rvalid;

            if (do_write) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
                if (wr_addr[7:6] == 2'b00) begin
                    regs[wr_addr[5:2]] <= wr_data;
                    bresp <= axil_pkg::RESP_OKAY;
                end else begin
                    bresp <= axil_pkg::RESP_SLVERR;
                end
            end else begin
                if (aw_now) aw_held <= 1'b1;
                if (w_now) w_held <= 1'b1;
                if (bvalid && bready) bvalid <= 1'b0;
            end

            if (ar_now) begin
                rvalid <= 1'b1;
                // out of range reads return zero
                rdata  <= (araddr[7:6] == 2'b00) ? regs[araddr[5:2]] : '0;
                rresp  <= (araddr[7:6] == 2'b00) ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/axil_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_subsys (
    input  logic            clk,
    input  logic            rst,
    input  logic            c0_req_valid,
    input  logic            c0_req_write,
    input  axil_pkg::addr_t c0_req_addr,
    input  axil_pkg::data_t c0_req_wdata,
    output logic            c0_credit_return,
    output logic            c0_rsp_valid,
    output axil_pkg::data_t c0_rsp_rdata,
    output logic            c0_rsp_err,
    input  logic            c1_req_valid,
    input  logic            c1_req_write,
    input  axil_pkg::addr_t c1_req_addr,
    input  axil_pkg::data_t c1_req_wdata,
    output logic            c1_credit_return,
    output logic            c1_rsp_valid,
    output axil_pkg::data_t c1_rsp_rdata,
    output logic            c1_rsp_err
);
    logic            c0_not_empty, c1_not_empty;
    logic            c0_head_write, c1_head_write;
    axil_pkg::addr_t c0_head_addr, c1_head_addr;
    axil_pkg::data_t c0_head_wdata, c1_head_wdata;
    logic            c0_pop, c1_pop;

    logic            start, start_write, done, done_err;
    axil_pkg::addr_t start_addr;
    axil_pkg::data_t start_wdata, done_rdata;
    axil_pkg::data_t rsp_rdata;
    logic            rsp_err;

    logic            awvalid, awready, wvalid, wready, bvalid, bready;
    logic            arvalid, arready, rvalid, rready;
    axil_pkg::addr_t awaddr, araddr;
    axil_pkg::data_t wdata, rdata;
    axil_pkg::resp_t bresp, rresp;

    req_fifo i_fifo0 (
        .clk(clk), .rst(rst),
        .push(c0_req_valid), .push_write(c0_req_write),
        .push_addr(c0_req_addr), .push_wdata(c0_req_wdata), .pop(c0_pop),
        .not_empty(c0_not_empty), .head_write(c0_head_write),
        .head_addr(c0_head_addr), .head_wdata(c0_head_wdata),
        .credit_return(c0_credit_return)
    );

    req_fifo i_fifo1 (
        .clk(clk), .rst(rst),
        .push(c1_req_valid), .push_write(c1_req_write),
        .push_addr(c1_req_addr), .push_wdata(c1_req_wdata), .pop(c1_pop),
        .not_empty(c1_not_empty), .head_write(c1_head_write),
        .head_addr(c1_head_addr), .head_wdata(c1_head_wdata),
        .credit_return(c1_credit_return)
    );

    bus_arbiter i_arbiter (
        .clk(clk), .rst(rst),
        .c0_not_empty(c0_not_empty), .c1_not_empty(c1_not_empty),
        .c0_head_write(c0_head_write), .c1_head_write(c1_head_write),
        .c0_head_addr(c0_head_addr), .c1_head_addr(c1_head_addr),
        .c0_head_wdata(c0_head_wdata), .c1_head_wdata(c1_head_wdata),
        .done(done), .done_rdata(done_rdata), .done_err(done_err),
        .c0_pop(c0_pop), .c1_pop(c1_pop),
        .start(start), .start_write(start_write),
        .start_addr(start_addr), .start_wdata(start_wdata),
        .c0_rsp_valid(c0_rsp_valid), .c1_rsp_valid(c1_rsp_valid),
        .rsp_rdata(rsp_rdata), .rsp_err(rsp_err)
    );

    axil_master i_master (
        .clk(clk), .rst(rst),
        .start(start), .start_write(start_write),
        .start_addr(start_addr), .start_wdata(start_wdata),
        .awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
        .arready(arready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp),
        .done(done), .done_rdata(done_rdata), .done_err(done_err),
        .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
        .bready(bready), .arvalid(arvalid), .araddr(araddr), .rready(rready)
    );

    axil_regfile i_regfile (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
        .bready(bready), .arvalid(arvalid), .araddr(araddr), .rready(rready),
        .awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
        .arready(arready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp)
    );

    // shared response payload, qualified per client by rsp_valid
    assign c0_rsp_rdata = rsp_rdata;
    assign c1_rsp_rdata = rsp_rdata;
    assign c0_rsp_err   = rsp_err;
    assign c1_rsp_err   = rsp_err;

endmodule

`default_nettype wire

/* logic/bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            c0_not_empty,
    input  logic            c1_not_empty,
    input  logic            c0_head_write,
    input  logic            c1_head_write,
    input  axil_pkg::addr_t c0_head_addr,
    input  axil_pkg::addr_t c1_head_addr,
    input  axil_pkg::data_t c0_head_wdata,
    input  axil_pkg::data_t c1_head_wdata,
    input  logic            done,
    input  axil_pkg::data_t done_rdata,
    input  logic            done_err,
    output logic            c0_pop,
    output logic            c1_pop,
    output logic            start,
    output logic            start_write,
    output axil_pkg::addr_t start_addr,
    output axil_pkg::data_t start_wdata,
    output logic            c0_rsp_valid,
    output logic            c1_rsp_valid,
    output axil_pkg::data_t rsp_rdata,
    output logic            rsp_err
);
    logic              busy;
    axil_pkg::client_t prio;
    axil_pkg::client_t owner;
    axil_pkg::client_t sel;

    // client 1 wins only with priority or when client 0 has nothing
    assign sel = c1_not_empty && (prio || !c0_not_empty);

    assign start       = !busy && (c0_not_empty || c1_not_empty);
    assign c0_pop      = start && !sel;
    assign c1_pop      = start && sel;
    assign start_write = sel ? c1_head_write : c0_head_write;
    assign start_addr  = sel ? c1_head_addr  : c0_head_addr;
    assign start_wdata = sel ? c1_head_wdata : c0_head_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            prio  <= 1'b0;
            owner <= 1'b0;
        end else if (start) begin
            busy  <= 1'b1;
            owner <= sel;
            prio  <= !sel;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    assign c0_rsp_valid = done && !owner;
    assign c1_rsp_valid = done && owner;
    assign rsp_rdata    = done_rdata;
    assign rsp_err      = done_err;

endmodule

`default_nettype wire

/* logic/req_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module req_fifo (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  logic            push_write,
    input  axil_pkg::addr_t push_addr,
    input  axil_pkg::data_t push_wdata,
    input  logic            pop,
    output logic            not_empty,
    output logic            head_write,
    output axil_pkg::addr_t head_addr,
    output axil_pkg::data_t head_wdata,
    output logic            credit_return
);
    logic            q_write [axil_pkg::REQ_CREDITS];
    axil_pkg::addr_t q_addr  [axil_pkg::REQ_CREDITS];
    axil_pkg::data_t q_wdata [axil_pkg::REQ_CREDITS];

    logic [axil_pkg::REQ_PTR_W-1:0] wr_ptr;
    logic [axil_pkg::REQ_PTR_W-1:0] rd_ptr;
    logic [axil_pkg::REQ_PTR_W:0]   count;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count         <= count + push - pop;
            // one credit back per popped entry
            credit_return <= pop;
        end
    end

    // queue storage
    always_ff @(posedge clk) begin
        if (push) begin
            q_write[wr_ptr] <= push_write;
            q_addr[wr_ptr]  <= push_addr;
            q_wdata[wr_ptr] <= push_wdata;
        end
    end

    assign not_empty  = (count != '0);
    assign head_write = q_write[rd_ptr];
    assign head_addr  = q_addr[rd_ptr];
    assign head_wdata = q_wdata[rd_ptr];

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build with verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f \
    --Mdir obj_dir -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 ; cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAILED"; exit 1; }
grep -q "Done: no errors" sim.log && echo "PASSED" || { echo "FAILED"; exit 1; }

/* tb.f */
logic/axil_pkg.sv
logic/req_fifo.sv
logic/bus_arbiter.sv
logic/axil_master.sv
logic/axil_regfile.sv
logic/axil_subsys.sv
test/tb_clock.sv
test/axil_assert.sv
test/tb_checker.sv
test/tb_top.sv

/* test/axil_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_assert (
    input logic clk,
    input logic rst,
    input logic start,
    input logic done,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic arvalid,
    input logic arready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready
);
    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        (awvalid && !awready) |=> awvalid)
        else $error("awvalid dropped before awready");

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        (wvalid && !wready) |=> wvalid)
        else $error("wvalid dropped before wready");

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        (arvalid && !arready) |=> arvalid)
        else $error("arvalid dropped before arready");

    a_bready: assert property (@(posedge clk) disable iff (rst) bvalid |-> bready)
        else $error("bvalid not accepted in its own cycle");

    a_rready: assert property (@(posedge clk) disable iff (rst) rvalid |-> rready)
        else $error("rvalid not accepted in its own cycle");

    a_done_start: assert property (@(posedge clk) disable iff (rst) !(done && start))
        else $error("done and start high together");

endmodule

bind axil_master axil_assert i_assert (
    .clk(clk), .rst(rst), .start(start), .done(done),
    .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
    .arvalid(arvalid), .arready(arready), .bvalid(bvalid), .bready(bready),
    .rvalid(rvalid), .rready(rready)
);

`default_nettype wire

/* test/tb_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
    input  logic            clk,
    input  logic            rst,
    input  logic            c0_req_valid,
    input  logic            c0_req_write,
    input  axil_pkg::addr_t c0_req_addr,
    input  axil_pkg::data_t c0_req_wdata,
    input  logic            c0_credit_return,
    input  logic            c0_rsp_valid,
    input  axil_pkg::data_t c0_rsp_rdata,
    input  logic            c0_rsp_err,
    input  logic            c1_req_valid,
    input  logic            c1_req_write,
    input  axil_pkg::addr_t c1_req_addr,
    input  axil_pkg::data_t c1_req_wdata,
    input  logic            c1_credit_return,
    input  logic            c1_rsp_valid,
    input  axil_pkg::data_t c1_rsp_rdata,
    input  logic            c1_rsp_err,
    input  int              test_num,
    input  logic            test_done,
    output int              outstanding,
    output int              err_count,
    output int              check_count
);
    // pending request word is {write, addr, wdata}
    logic [40:0]     pend0 [$];
    logic [40:0]     pend1 [$];
    axil_pkg::data_t model [axil_pkg::NUM_REGS];
    int              inflight [2];
    int              in_service;
    int              errs = 0;
    int              checks = 0;
    int              test_errs = 0;
    int              test_checks = 0;
    logic            after_rst = 1'b0;

    assign err_count   = errs;
    assign check_count = checks;

    function automatic string test_name(input int n);
        case (n)
            1: return "reset state";
            2: return "write and read back";
            3: return "error responses";
            4: return "two clients";
            5: return "credit flow";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errs++;
        test_errs++;
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        checks++;
        test_checks++;
        if (exp !== got) begin
            report_problem($sformatf("FAIL %s expected %h got %h", name, exp, got));
        end
    endtask

    // responses are serialized and arrive in execution order
    task automatic take_response(input int c, input axil_pkg::data_t rdata, input logic err);
        logic [40:0]     req;
        logic            bad;
        axil_pkg::data_t exp_rdata;
        if ((c == 0 && pend0.size() == 0) || (c == 1 && pend1.size() == 0)) begin
            report_problem($sformatf("client %0d got a response with no request pending", c));
            return;
        end
        if (c == 0) begin
            req = pend0.pop_front();
        end else begin
            req = pend1.pop_front();
        end
        bad = (req[39:38] != 2'b00);
        compare_value($sformatf("c%0d_rsp_err", c), {31'b0, bad}, {31'b0, err});
        if (req[40]) begin
            if (!bad) model[req[37:34]] = req[31:0];
        end else begin
            exp_rdata = bad ? '0 : model[req[37:34]];
            compare_value($sformatf("c%0d_rsp_rdata", c), exp_rdata, rdata);
        end
    endtask

    task automatic count_credit(input int c, input logic ret, input logic push);
        if (ret) begin
            if (inflight[c] == 0) begin
                report_problem($sformatf("client %0d got a credit back with none in use", c));
            end else begin
                inflight[c]--;
            end
        end
        if (push) inflight[c]++;
    endtask

    task automatic end_test();
        if (pend0.size() != 0 || pend1.size() != 0) begin
            report_problem("test ended with responses still missing");
        end
        if (inflight[0] != 0 || inflight[1] != 0) begin
            report_problem("test ended with credits not returned");
        end
        if (test_errs == 0) begin
            $display("test %0d %s: %0d checks ok", test_num, test_name(test_num), test_checks);
        end else begin
            $display("test %0d %s: %0d checks, %0d errors", test_num, test_name(test_num),
                     test_checks, test_errs);
        end
        test_errs   = 0;
        test_checks = 0;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            pend0.delete();
            pend1.delete();
            inflight[0] = 0;
            inflight[1] = 0;
            for (int i = 0; i < axil_pkg::NUM_REGS; i++) model[i] = '0;
            after_rst = 1'b1;
        end else begin
            // all outputs quiet in the first cycle out of reset
            if (after_rst) begin
                compare_value("c0_credit_return", 32'h0, {31'b0, c0_credit_return});
                compare_value("c1_credit_return", 32'h0, {31'b0, c1_credit_return});
                compare_value("c0_rsp_valid", 32'h0, {31'b0, c0_rsp_valid});
                compare_value("c1_rsp_valid", 32'h0, {31'b0, c1_rsp_valid});
                after_rst = 1'b0;
            end
            if (c0_rsp_valid && c1_rsp_valid) begin
                report_problem("both clients got a response in the same cycle");
            end
            // a response always belongs to an older request than this cycle's push
            if (c0_rsp_valid) take_response(0, c0_rsp_rdata, c0_rsp_err);
            if (c1_rsp_valid) take_response(1, c1_rsp_rdata, c1_rsp_err);
            count_credit(0, c0_credit_return, c0_req_valid);
            count_credit(1, c1_credit_return, c1_req_valid);
            if (c0_req_valid) pend0.push_back({c0_req_write, c0_req_addr, c0_req_wdata});
            if (c1_req_valid) pend1.push_back({c1_req_write, c1_req_addr, c1_req_wdata});
            // requests whose credit came back but whose response has not
            in_service = (pend0.size() - inflight[0]) + (pend1.size() - inflight[1]);
            if (in_service < 0 || in_service > 1) begin
                report_problem($sformatf("credits out of step with responses: %0d in service",
                                         in_service));
            end
            if (test_done) end_test();
        end
        outstanding = pend0.size() + pend1.size();
    end

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);
    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset seen on 8 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* test/tb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_top;
    localparam int T1_REQS = 16;
    localparam int T2_REQS = 48;
    localparam int T3_BAD  = 12;
    localparam int T3_REQS = T3_BAD + 16;
    localparam int T4_REQS = 60;
    localparam int T5_REQS = 60;
    // a write needs about 7 cycles, so 12 per request covers idle gaps too
    localparam int TIMEOUT_CYCLES =
        (T1_REQS + T2_REQS + T3_REQS + T4_REQS + T5_REQS) * 12 + 200;

    logic            clk;
    logic            rst;
    logic            c0_req_valid, c1_req_valid;
    logic            c0_req_write, c1_req_write;
    axil_pkg::addr_t c0_req_addr, c1_req_addr;
    axil_pkg::data_t c0_req_wdata, c1_req_wdata;
    logic            c0_credit_return, c1_credit_return;
    logic            c0_rsp_valid, c1_rsp_valid;
    axil_pkg::data_t c0_rsp_rdata, c1_rsp_rdata;
    logic            c0_rsp_err, c1_rsp_err;

    int              test_num;
    logic            test_done;
    int              outstanding;
    int              err_count;
    int              check_count;
    int              tests_run;
    int              cycles;
    logic            timed_out;

    logic [31:0]     lfsr;
    int              credits [2];
    // queued stimulus per client, {write, addr, wdata}
    logic [40:0]     plan0 [$];
    logic [40:0]     plan1 [$];

    tb_clock i_clock (.clk(clk), .rst(rst));

    axil_subsys i_dut (
        .clk(clk), .rst(rst),
        .c0_req_valid(c0_req_valid), .c0_req_write(c0_req_write),
        .c0_req_addr(c0_req_addr), .c0_req_wdata(c0_req_wdata),
        .c0_credit_return(c0_credit_return), .c0_rsp_valid(c0_rsp_valid),
        .c0_rsp_rdata(c0_rsp_rdata), .c0_rsp_err(c0_rsp_err),
        .c1_req_valid(c1_req_valid), .c1_req_write(c1_req_write),
        .c1_req_addr(c1_req_addr), .c1_req_wdata(c1_req_wdata),
        .c1_credit_return(c1_credit_return), .c1_rsp_valid(c1_rsp_valid),
        .c1_rsp_rdata(c1_rsp_rdata), .c1_rsp_err(c1_rsp_err)
    );

    tb_checker i_checker (
        .clk(clk), .rst(rst),
        .c0_req_valid(c0_req_valid), .c0_req_write(c0_req_write),
        .c0_req_addr(c0_req_addr), .c0_req_wdata(c0_req_wdata),
        .c0_credit_return(c0_credit_return), .c0_rsp_valid(c0_rsp_valid),
        .c0_rsp_rdata(c0_rsp_rdata), .c0_rsp_err(c0_rsp_err),
        .c1_req_valid(c1_req_valid), .c1_req_write(c1_req_write),
        .c1_req_addr(c1_req_addr), .c1_req_wdata(c1_req_wdata),
        .c1_credit_return(c1_credit_return), .c1_rsp_valid(c1_rsp_valid),
        .c1_rsp_rdata(c1_rsp_rdata), .c1_rsp_err(c1_rsp_err),
        .test_num(test_num), .test_done(test_done), .outstanding(outstanding),
        .err_count(err_count), .check_count(check_count)
    );

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
            v    = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic axil_pkg::addr_t word_addr(input logic [3:0] idx);
        logic [31:0] low;
        low = rand_bits(2);
        return {2'b00, idx, low[1:0]};
    endfunction

    // bits 7:6 never both zero
    function automatic axil_pkg::addr_t bad_addr();
        logic [31:0] r;
        r = rand_bits(8);
        if (r[7:6] == 2'b00) r[7] = 1'b1;
        return r[7:0];
    endfunction

    // random traffic, client 0 on registers 0..7 and client 1 on 8..15
    task automatic fill_halves(input int n);
        logic [31:0] wr;
        logic [31:0] idx;
        logic [31:0] data;
        for (int i = 0; i < n; i++) begin
            wr   = rand_bits(1);
            idx  = rand_bits(3);
            data = rand_bits(32);
            plan0.push_back({wr[0], word_addr({1'b0, idx[2:0]}), data});
            wr   = rand_bits(1);
            idx  = rand_bits(3);
            data = rand_bits(32);
            plan1.push_back({wr[0], word_addr({1'b1, idx[2:0]}), data});
        end
    endtask

    task automatic pick_request(input int c, input logic ret, input logic full_rate,
                                output logic valid, output logic [40:0] req);
        logic go;
        int   left;
        if (ret) credits[c]++;
        valid = 1'b0;
        req   = '0;
        left  = (c == 0) ? plan0.size() : plan1.size();
        if (credits[c] > 0 && left != 0) begin
            go = full_rate ? 1'b1 : (rand_bits(1) != 0);
            if (go) begin
                if (c == 0) begin
                    req = plan0.pop_front();
                end else begin
                    req = plan1.pop_front();
                end
                valid = 1'b1;
                credits[c]--;
            end
        end
    endtask

    // drive until both plans are sent and every response is back
    task automatic run_test(input int n, input logic full_rate);
        logic        v0, v1;
        logic [40:0] r0, r1;
        test_num = n;
        while (plan0.size() != 0 || plan1.size() != 0 || outstanding != 0
               || credits[0] != axil_pkg::REQ_CREDITS || credits[1] != axil_pkg::REQ_CREDITS) begin
            @(negedge clk);
            pick_request(0, c0_credit_return, full_rate, v0, r0);
            pick_request(1, c1_credit_return, full_rate, v1, r1);
            c0_req_valid = v0;
            {c0_req_write, c0_req_addr, c0_req_wdata} = r0;
            c1_req_valid = v1;
            {c1_req_write, c1_req_addr, c1_req_wdata} = r1;
        end
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
        @(negedge clk);
        tests_run++;
    endtask

    task automatic finish_run();
        int errors;
        errors = err_count + (timed_out ? 1 : 0);
        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        logic [3:0]  addrs [T2_REQS/2];
        logic [31:0] r;
        logic [31:0] data;
        c0_req_valid = 1'b0;
        c0_req_write = 1'b0;
        c0_req_addr  = '0;
        c0_req_wdata = '0;
        c1_req_valid = 1'b0;
        c1_req_write = 1'b0;
        c1_req_addr  = '0;
        c1_req_wdata = '0;
        test_num     = 0;
        test_done    = 1'b0;
        tests_run    = 0;
        credits[0]   = axil_pkg::REQ_CREDITS;
        credits[1]   = axil_pkg::REQ_CREDITS;
        lfsr         = 32'h5929_8270;
        @(negedge clk);
        while (rst) @(negedge clk);

        // every register reads back zero
        for (int i = 0; i < axil_pkg::NUM_REGS; i++) begin
            plan0.push_back({1'b0, word_addr(4'(i)), 32'h0});
        end
        run_test(1, 1'b1);

        for (int i = 0; i < T2_REQS/2; i++) begin
            r        = rand_bits(4);
            addrs[i] = r[3:0];
            data     = rand_bits(32);
            plan0.push_back({1'b1, word_addr(addrs[i]), data});
        end
        for (int i = 0; i < T2_REQS/2; i++) begin
            plan0.push_back({1'b0, word_addr(addrs[i]), 32'h0});
        end
        run_test(2, 1'b0);

        // out of range mix, then a sweep showing nothing changed
        for (int i = 0; i < T3_BAD; i++) begin
            r    = rand_bits(1);
            data = rand_bits(32);
            plan0.push_back({r[0], bad_addr(), data});
        end
        for (int i = 0; i < axil_pkg::NUM_REGS; i++) begin
            plan0.push_back({1'b0, word_addr(4'(i)), 32'h0});
        end
        run_test(3, 1'b0);

        fill_halves(T4_REQS/2);
        run_test(4, 1'b0);

        // every cycle that a credit allows
        fill_halves(T5_REQS/2);
        run_test(5, 1'b1);

        finish_run();
    end

    initial begin
        timed_out = 1'b0;
        cycles    = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: traffic did not drain within %0d cycles", TIMEOUT_CYCLES);
        timed_out = 1'b1;
        finish_run();
    end

endmodule

`default_nettype wire
